// ==== rtl/sigdecode_z_pkg.sv ====
package sigdecode_z_pkg;

    // ====================
    // Scheme constants
    // ====================

    // ML-DSA modulus q = 2^23 - 2^13 + 1
    localparam logic [31:0] MLDSA_Q = 32'd8380417;

    // Default address width of the signature and destination memories
    localparam int DEF_MEM_ADDR_WIDTH = 15;

    // Width of one decoded coefficient in the destination memory
    localparam int DEF_REG_SIZE = 24;

    // gamma1 = 2^19 for ML-DSA-65/87, so a z coefficient takes 20 bits encoded
    localparam int DEF_GAMMA1_BITS = 19;

    // L * N / 4 source words, with L = 7 and N = 256 for ML-DSA-87
    localparam int DEF_NUM_WORDS = 448;

    // ====================
    // Types
    // ====================

    // Memory command carried next to each address port
    typedef enum logic [1:0] {
        RW_IDLE  = 2'b00,
        RW_READ  = 2'b01,
        RW_WRITE = 2'b10
    } rw_cmd_e;

    // The read, decode and write phases overlap, so the middle states name all active stages
    typedef enum logic [2:0] {
        ST_IDLE            = 3'b000,
        ST_READ            = 3'b001,
        ST_READ_EXEC       = 3'b010,
        ST_READ_EXEC_WRITE = 3'b011,
        ST_EXEC_WRITE      = 3'b100,
        ST_WRITE           = 3'b101,
        ST_DONE            = 3'b110
    } sigdecode_z_state_e;

endpackage

// ==== rtl/sigdecode_z_unit.sv ====
`timescale 1ns/10ps

module sigdecode_z_unit #(
    parameter int REG_SIZE    = 24,
    parameter int GAMMA1_BITS = 19
) (
    input  logic                   clk,
    input  logic                   reset_n,
    input  logic                   zeroize,
    input  logic [GAMMA1_BITS:0]   data_in,
    output logic [REG_SIZE-1:0]    data_out
);

    // One extra bit over the code holds the sign of gamma1 - code
    localparam int DW = GAMMA1_BITS + 2;
    localparam logic [DW-1:0] GAMMA1 = DW'(1) << GAMMA1_BITS;
    localparam logic [REG_SIZE-1:0] Q_R = REG_SIZE'(sigdecode_z_pkg::MLDSA_Q);

    logic [DW-1:0]       diff;
    logic [REG_SIZE-1:0] diff_ext;
    logic [REG_SIZE-1:0] decoded;

    // The code is stored as gamma1 - z, so z = gamma1 - code lies in (-gamma1, gamma1]
    assign diff     = GAMMA1 - {1'b0, data_in};
    assign diff_ext = {{(REG_SIZE-DW){diff[DW-1]}}, diff};

    // Negative values wrap to q + z; the sum stays below 2^REG_SIZE
    assign decoded = diff[DW-1] ? (diff_ext + Q_R) : diff_ext;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            data_out <= '0;
        end
        else if (zeroize) begin
            data_out <= '0;
        end
        else begin
            data_out <= decoded;
        end
    end

endmodule

// ==== rtl/sigdecode_z_ctrl.sv ====
`timescale 1ns/10ps

module sigdecode_z_ctrl (
    input  logic clk,
    input  logic reset_n,
    input  logic zeroize,
    input  logic enable,
    input  logic last_rd_pair,
    output logic rd_phase,
    output logic wr_phase,
    output logic done
);

    sigdecode_z_pkg::sigdecode_z_state_e state;
    sigdecode_z_pkg::sigdecode_z_state_e next_state;

    // Set one cycle after ST_DONE, so done trails the last write by a full cycle
    logic done_pending;

    // ====================
    // State register
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= sigdecode_z_pkg::ST_IDLE;
        end
        else if (zeroize) begin
            state <= sigdecode_z_pkg::ST_IDLE;
        end
        else begin
            state <= next_state;
        end
    end

    // ====================
    // Next state
    // ====================

    always_comb begin
        next_state = state;
        case (state)
            sigdecode_z_pkg::ST_IDLE: begin
                if (enable) begin
                    next_state = sigdecode_z_pkg::ST_READ;
                end
            end
            sigdecode_z_pkg::ST_READ: begin
                next_state = sigdecode_z_pkg::ST_READ_EXEC;
            end
            sigdecode_z_pkg::ST_READ_EXEC: begin
                next_state = sigdecode_z_pkg::ST_READ_EXEC_WRITE;
            end
            sigdecode_z_pkg::ST_READ_EXEC_WRITE: begin
                // The final read pair goes out from this cycle, then the pipe drains
                if (last_rd_pair) begin
                    next_state = sigdecode_z_pkg::ST_EXEC_WRITE;
                end
            end
            sigdecode_z_pkg::ST_EXEC_WRITE: begin
                next_state = sigdecode_z_pkg::ST_WRITE;
            end
            sigdecode_z_pkg::ST_WRITE: begin
                next_state = sigdecode_z_pkg::ST_DONE;
            end
            sigdecode_z_pkg::ST_DONE: begin
                next_state = sigdecode_z_pkg::ST_IDLE;
            end
            default: begin
                next_state = sigdecode_z_pkg::ST_IDLE;
            end
        endcase
    end

    // Phase levels for the address counter
    assign rd_phase = (state == sigdecode_z_pkg::ST_READ) ||
                      (state == sigdecode_z_pkg::ST_READ_EXEC) ||
                      (state == sigdecode_z_pkg::ST_READ_EXEC_WRITE);

    assign wr_phase = (state == sigdecode_z_pkg::ST_READ_EXEC_WRITE) ||
                      (state == sigdecode_z_pkg::ST_EXEC_WRITE) ||
                      (state == sigdecode_z_pkg::ST_WRITE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            done_pending <= 1'b0;
            done         <= 1'b0;
        end
        else if (zeroize) begin
            done_pending <= 1'b0;
            done         <= 1'b0;
        end
        else begin
            done_pending <= (state == sigdecode_z_pkg::ST_DONE);
            done         <= done_pending;
        end
    end

endmodule

// ==== rtl/sigdecode_z_addr_counter.sv ====
`timescale 1ns/10ps

module sigdecode_z_addr_counter #(
    parameter int MEM_ADDR_WIDTH = 15,
    parameter int NUM_WORDS      = 448
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic                             enable,
    input  logic [MEM_ADDR_WIDTH-1:0]        src_base_addr,
    input  logic [MEM_ADDR_WIDTH-1:0]        dest_base_addr,
    input  logic                             rd_phase,
    input  logic                             wr_phase,
    output logic                             last_rd_pair,
    output sigdecode_z_pkg::rw_cmd_e         rd_a_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        rd_a_addr,
    output sigdecode_z_pkg::rw_cmd_e         rd_b_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        rd_b_addr,
    output sigdecode_z_pkg::rw_cmd_e         wr_a_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        wr_a_addr,
    output sigdecode_z_pkg::rw_cmd_e         wr_b_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        wr_b_addr
);

    // Counters hold the even word offset of the current pair, at most NUM_WORDS-2
    localparam int CNT_W = $clog2(NUM_WORDS);

    logic [MEM_ADDR_WIDTH-1:0] src_lock;
    logic [MEM_ADDR_WIDTH-1:0] dest_lock;
    logic [CNT_W-1:0]          rd_count;
    logic [CNT_W-1:0]          wr_count;
    logic [MEM_ADDR_WIDTH-1:0] rd_pair_addr;
    logic [MEM_ADDR_WIDTH-1:0] wr_pair_addr;

    // ====================
    // Base address lock
    // ====================

    // A pulse on enable captures both bases; later changes on the inputs are ignored
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            src_lock  <= '0;
            dest_lock <= '0;
        end
        else if (zeroize) begin
            src_lock  <= '0;
            dest_lock <= '0;
        end
        else if (enable) begin
            src_lock  <= src_base_addr;
            dest_lock <= dest_base_addr;
        end
    end

    // ====================
    // Word pair counters
    // ====================

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_count <= '0;
            wr_count <= '0;
        end
        else if (zeroize) begin
            rd_count <= '0;
            wr_count <= '0;
        end
        else begin
            rd_count <= rd_phase ? (rd_count + CNT_W'(2)) : '0;
            wr_count <= wr_phase ? (wr_count + CNT_W'(2)) : '0;
        end
    end

    // The pair issued from this count is the last one of the run
    assign last_rd_pair = (rd_count == CNT_W'(NUM_WORDS - 2));

    assign rd_pair_addr = src_lock + MEM_ADDR_WIDTH'(rd_count);
    assign wr_pair_addr = dest_lock + MEM_ADDR_WIDTH'(wr_count);

    // ====================
    // Memory requests
    // ====================

    // Port A takes the even word of a pair and port B the odd one
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_a_cmd  <= sigdecode_z_pkg::RW_IDLE;
            rd_a_addr <= '0;
            rd_b_cmd  <= sigdecode_z_pkg::RW_IDLE;
            rd_b_addr <= '0;
        end
        else if (zeroize || !rd_phase) begin
            rd_a_cmd  <= sigdecode_z_pkg::RW_IDLE;
            rd_a_addr <= '0;
            rd_b_cmd  <= sigdecode_z_pkg::RW_IDLE;
            rd_b_addr <= '0;
        end
        else begin
            rd_a_cmd  <= sigdecode_z_pkg::RW_READ;
            rd_a_addr <= rd_pair_addr;
            rd_b_cmd  <= sigdecode_z_pkg::RW_READ;
            rd_b_addr <= rd_pair_addr + MEM_ADDR_WIDTH'(1);
        end
    end

    // Writes line up with the decoder output, two cycles behind the matching read
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_a_cmd  <= sigdecode_z_pkg::RW_IDLE;
            wr_a_addr <= '0;
            wr_b_cmd  <= sigdecode_z_pkg::RW_IDLE;
            wr_b_addr <= '0;
        end
        else if (zeroize || !wr_phase) begin
            wr_a_cmd  <= sigdecode_z_pkg::RW_IDLE;
            wr_a_addr <= '0;
            wr_b_cmd  <= sigdecode_z_pkg::RW_IDLE;
            wr_b_addr <= '0;
        end
        else begin
            wr_a_cmd  <= sigdecode_z_pkg::RW_WRITE;
            wr_a_addr <= wr_pair_addr;
            wr_b_cmd  <= sigdecode_z_pkg::RW_WRITE;
            wr_b_addr <= wr_pair_addr + MEM_ADDR_WIDTH'(1);
        end
    end

endmodule

// ==== rtl/sigdecode_z_top.sv ====
`timescale 1ns/10ps

module sigdecode_z_top #(
    parameter int MEM_ADDR_WIDTH = sigdecode_z_pkg::DEF_MEM_ADDR_WIDTH,
    parameter int REG_SIZE       = sigdecode_z_pkg::DEF_REG_SIZE,
    parameter int GAMMA1_BITS    = sigdecode_z_pkg::DEF_GAMMA1_BITS,
    // Must be even and at least 6 so that all three read states are visited
    parameter int NUM_WORDS      = sigdecode_z_pkg::DEF_NUM_WORDS
) (
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             zeroize,
    input  logic                             enable,

    // Source signature memory, two read ports
    input  logic [MEM_ADDR_WIDTH-1:0]        src_base_addr,
    output sigdecode_z_pkg::rw_cmd_e         rd_a_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        rd_a_addr,
    output sigdecode_z_pkg::rw_cmd_e         rd_b_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        rd_b_addr,
    input  logic [3:0][GAMMA1_BITS:0]        rd_a_data,
    input  logic [3:0][GAMMA1_BITS:0]        rd_b_data,

    // Destination memory, two write ports
    input  logic [MEM_ADDR_WIDTH-1:0]        dest_base_addr,
    output sigdecode_z_pkg::rw_cmd_e         wr_a_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        wr_a_addr,
    output sigdecode_z_pkg::rw_cmd_e         wr_b_cmd,
    output logic [MEM_ADDR_WIDTH-1:0]        wr_b_addr,
    output logic [3:0][REG_SIZE-1:0]         wr_a_data,
    output logic [3:0][REG_SIZE-1:0]         wr_b_data,

    output logic                             done
);

    logic rd_phase;
    logic wr_phase;
    logic last_rd_pair;

    // ====================
    // Sequencing
    // ====================

    sigdecode_z_ctrl u_ctrl (
        .clk          (clk),
        .reset_n      (reset_n),
        .zeroize      (zeroize),
        .enable       (enable),
        .last_rd_pair (last_rd_pair),
        .rd_phase     (rd_phase),
        .wr_phase     (wr_phase),
        .done         (done)
    );

    sigdecode_z_addr_counter #(
        .MEM_ADDR_WIDTH (MEM_ADDR_WIDTH),
        .NUM_WORDS      (NUM_WORDS)
    ) u_addr_counter (
        .clk            (clk),
        .reset_n        (reset_n),
        .zeroize        (zeroize),
        .enable         (enable),
        .src_base_addr  (src_base_addr),
        .dest_base_addr (dest_base_addr),
        .rd_phase       (rd_phase),
        .wr_phase       (wr_phase),
        .last_rd_pair   (last_rd_pair),
        .rd_a_cmd       (rd_a_cmd),
        .rd_a_addr      (rd_a_addr),
        .rd_b_cmd       (rd_b_cmd),
        .rd_b_addr      (rd_b_addr),
        .wr_a_cmd       (wr_a_cmd),
        .wr_a_addr      (wr_a_addr),
        .wr_b_cmd       (wr_b_cmd),
        .wr_b_addr      (wr_b_addr)
    );

    // ====================
    // Decoders
    // ====================

    // Four coefficients per word and two words per cycle
    for (genvar i = 0; i < 4; i++) begin : g_dec
        sigdecode_z_unit #(
            .REG_SIZE    (REG_SIZE),
            .GAMMA1_BITS (GAMMA1_BITS)
        ) u_dec_a (
            .clk      (clk),
            .reset_n  (reset_n),
            .zeroize  (zeroize),
            .data_in  (rd_a_data[i]),
            .data_out (wr_a_data[i])
        );

        sigdecode_z_unit #(
            .REG_SIZE    (REG_SIZE),
            .GAMMA1_BITS (GAMMA1_BITS)
        ) u_dec_b (
            .clk      (clk),
            .reset_n  (reset_n),
            .zeroize  (zeroize),
            .data_in  (rd_b_data[i]),
            .data_out (wr_b_data[i])
        );
    end

endmodule

// ==== sim/sigdecode_z_props.sv ====
`timescale 1ns/10ps

module sigdecode_z_props #(
    parameter int MEM_ADDR_WIDTH = 15
) (
    input logic                          clk,
    input logic                          reset_n,
    input sigdecode_z_pkg::rw_cmd_e      rd_a_cmd,
    input sigdecode_z_pkg::rw_cmd_e      rd_b_cmd,
    input sigdecode_z_pkg::rw_cmd_e      wr_a_cmd,
    input sigdecode_z_pkg::rw_cmd_e      wr_b_cmd,
    input logic [MEM_ADDR_WIDTH-1:0]     rd_a_addr,
    input logic [MEM_ADDR_WIDTH-1:0]     rd_b_addr,
    input logic [MEM_ADDR_WIDTH-1:0]     wr_a_addr,
    input logic [MEM_ADDR_WIDTH-1:0]     wr_b_addr,
    input logic                          done
);

    // Both ports of a memory move in lock step
    a_rd_same: assert property (@(posedge clk) disable iff (!reset_n) rd_a_cmd == rd_b_cmd)
        else $error("read commands on A and B differ");
    a_wr_same: assert property (@(posedge clk) disable iff (!reset_n) wr_a_cmd == wr_b_cmd)
        else $error("write commands on A and B differ");

    a_rd_pair: assert property (@(posedge clk) disable iff (!reset_n)
        rd_a_cmd == sigdecode_z_pkg::RW_READ |-> rd_b_addr == rd_a_addr + MEM_ADDR_WIDTH'(1))
        else $error("read B address is not A plus one");
    a_wr_pair: assert property (@(posedge clk) disable iff (!reset_n)
        wr_a_cmd == sigdecode_z_pkg::RW_WRITE |-> wr_b_addr == wr_a_addr + MEM_ADDR_WIDTH'(1))
        else $error("write B address is not A plus one");

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done)
        else $error("done held longer than one cycle");

    a_done_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        done |-> wr_a_cmd == sigdecode_z_pkg::RW_IDLE ##1 wr_a_cmd == sigdecode_z_pkg::RW_IDLE)
        else $error("write command near done");

endmodule

bind sigdecode_z_top sigdecode_z_props #(.MEM_ADDR_WIDTH(MEM_ADDR_WIDTH)) u_props (
    .clk       (clk),
    .reset_n   (reset_n),
    .rd_a_cmd  (rd_a_cmd),
    .rd_b_cmd  (rd_b_cmd),
    .wr_a_cmd  (wr_a_cmd),
    .wr_b_cmd  (wr_b_cmd),
    .rd_a_addr (rd_a_addr),
    .rd_b_addr (rd_b_addr),
    .wr_a_addr (wr_a_addr),
    .wr_b_addr (wr_b_addr),
    .done      (done)
);

// ==== sim/sigdecode_z_tb.sv ====
`timescale 1ns/10ps

module sigdecode_z_tb;

    localparam int AW = sigdecode_z_pkg::DEF_MEM_ADDR_WIDTH;
    localparam int RS = sigdecode_z_pkg::DEF_REG_SIZE;
    localparam int G  = sigdecode_z_pkg::DEF_GAMMA1_BITS;
    localparam int NW = 16;
    localparam int H  = NW / 2;
    localparam int ROWS = 4;
    localparam int LIMIT = ROWS * (H + 20) + 10;

    logic clk;
    logic reset_n;
    logic zeroize;
    logic enable;
    logic [AW-1:0] src_base_addr;
    logic [AW-1:0] dest_base_addr;
    logic [3:0][G:0] rd_a_data;
    logic [3:0][G:0] rd_b_data;
    sigdecode_z_pkg::rw_cmd_e rd_a_cmd;
    sigdecode_z_pkg::rw_cmd_e rd_b_cmd;
    sigdecode_z_pkg::rw_cmd_e wr_a_cmd;
    sigdecode_z_pkg::rw_cmd_e wr_b_cmd;
    logic [AW-1:0] rd_a_addr;
    logic [AW-1:0] rd_b_addr;
    logic [AW-1:0] wr_a_addr;
    logic [AW-1:0] wr_b_addr;
    logic [3:0][RS-1:0] wr_a_data;
    logic [3:0][RS-1:0] wr_b_data;
    logic done;

    logic [3:0][G:0]    src_mem [2**AW];
    logic [3:0][RS-1:0] dest_mem [2**AW];
    int seed = 4710;
    int errors = 0;
    int cycles = 0;
    int writes = 0;

    // Stimulus table with source base, destination base, abort cycle (-1 for none) and base change
    int tbl_src [ROWS] = '{'h010, 'h100, 'h040, 'h080};
    int tbl_dst [ROWS] = '{'h200, 'h300, 'h400, 'h500};
    int tbl_abort [ROWS] = '{-1, -1, 7, -1};
    int tbl_chg [ROWS] = '{0, 1, 0, 0};

    sigdecode_z_top #(.NUM_WORDS(NW)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", LIMIT);
            $display("Errors found");
            $finish;
        end
    end

    // ====================
    // Memory models
    // ====================

    always begin : mem_model
        sigdecode_z_pkg::rw_cmd_e a_cmd;
        sigdecode_z_pkg::rw_cmd_e b_cmd;
        logic [AW-1:0] a_addr;
        logic [AW-1:0] b_addr;
        @(posedge clk);
        a_cmd = rd_a_cmd;
        b_cmd = rd_b_cmd;
        a_addr = rd_a_addr;
        b_addr = rd_b_addr;
        if (wr_a_cmd == sigdecode_z_pkg::RW_WRITE) begin
            dest_mem[wr_a_addr] = wr_a_data;
            writes++;
        end
        if (wr_b_cmd == sigdecode_z_pkg::RW_WRITE) begin
            dest_mem[wr_b_addr] = wr_b_data;
            writes++;
        end
        #1;
        if (a_cmd == sigdecode_z_pkg::RW_READ) rd_a_data = src_mem[a_addr];
        if (b_cmd == sigdecode_z_pkg::RW_READ) rd_b_data = src_mem[b_addr];
    end

    // Reference decode gives gamma1 minus the code and adds q when that is negative
    function automatic logic [RS-1:0] expect_coef(input logic [G:0] code);
        longint z;
        z = (longint'(1) << G) - longint'(code);
        if (z < 0) z = z + longint'(sigdecode_z_pkg::MLDSA_Q);
        return RS'(z);
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic check_cmd(input string name, input sigdecode_z_pkg::rw_cmd_e exp,
                             input sigdecode_z_pkg::rw_cmd_e act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input logic [AW-1:0] exp,
                              input logic [AW-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_coef(input string name, input logic [RS-1:0] exp,
                              input logic [RS-1:0] act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %h actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_ports(input int src, input int dst, input int c, input bit live);
        sigdecode_z_pkg::rw_cmd_e rd_exp;
        sigdecode_z_pkg::rw_cmd_e wr_exp;
        logic [AW-1:0] ra;
        logic [AW-1:0] wa;
        int i;
        rd_exp = (live && c >= 2 && c <= H + 1) ? sigdecode_z_pkg::RW_READ
                                                 : sigdecode_z_pkg::RW_IDLE;
        wr_exp = (live && c >= 4 && c <= H + 3) ? sigdecode_z_pkg::RW_WRITE
                                                 : sigdecode_z_pkg::RW_IDLE;
        ra = (rd_exp == sigdecode_z_pkg::RW_READ) ? AW'(src + 2 * (c - 2)) : '0;
        wa = (wr_exp == sigdecode_z_pkg::RW_WRITE) ? AW'(dst + 2 * (c - 4)) : '0;
        check_cmd("rd_a_cmd", rd_exp, rd_a_cmd);
        check_cmd("rd_b_cmd", rd_exp, rd_b_cmd);
        check_cmd("wr_a_cmd", wr_exp, wr_a_cmd);
        check_cmd("wr_b_cmd", wr_exp, wr_b_cmd);
        check_addr("rd_a_addr", ra, rd_a_addr);
        check_addr("rd_b_addr",
                   (rd_exp == sigdecode_z_pkg::RW_READ) ? ra + AW'(1) : '0, rd_b_addr);
        check_addr("wr_a_addr", wa, wr_a_addr);
        check_addr("wr_b_addr",
                   (wr_exp == sigdecode_z_pkg::RW_WRITE) ? wa + AW'(1) : '0, wr_b_addr);
        check_bit("done", live && c == H + 5, done);
        if (wr_exp == sigdecode_z_pkg::RW_WRITE) begin
            for (i = 0; i < 4; i++) begin
                check_coef("wr_a_data", expect_coef(src_mem[AW'(src + 2 * (c - 4))][i]),
                           wr_a_data[i]);
                check_coef("wr_b_data", expect_coef(src_mem[AW'(src + 2 * (c - 4) + 1)][i]),
                           wr_b_data[i]);
            end
        end
    endtask

    task automatic run_test(input int row);
        int src;
        int dst;
        int abort_c;
        int c;
        int j;
        int i;
        int err_before;
        src = tbl_src[row];
        dst = tbl_dst[row];
        abort_c = tbl_abort[row];
        err_before = errors;
        writes = 0;
        @(posedge clk);
        #1;
        enable = 1'b1;
        src_base_addr = AW'(src);
        dest_base_addr = AW'(dst);
        // Edge E samples enable
        @(posedge clk);
        #1;
        enable = 1'b0;
        if (tbl_chg[row] != 0) begin
            src_base_addr = AW'(src + 'h1000);
            dest_base_addr = AW'(dst + 'h1000);
        end
        for (c = 1; c <= H + 7; c++) begin
            if (c > 1) begin
                @(posedge clk);
                #1;
            end
            zeroize = (c == abort_c);
            @(negedge clk);
            check_ports(src, dst, c, abort_c < 0 || c <= abort_c);
        end
        if (abort_c < 0) begin
            if (writes != NW) begin
                $display("Write count wrong: %0d words written, %0d expected", writes, NW);
                errors++;
            end
            for (j = 0; j < NW; j++) begin
                for (i = 0; i < 4; i++) begin
                    check_coef("dest_mem", expect_coef(src_mem[AW'(src + j)][i]),
                               dest_mem[AW'(dst + j)][i]);
                end
            end
        end
        $display("Test %0d src=%h dst=%h abort=%0d: %s", row, src, dst, abort_c,
                 (errors == err_before) ? "ok" : "mismatches");
    endtask

    initial begin : main
        int i;
        int r;
        reset_n = 1'b0;
        zeroize = 1'b0;
        enable = 1'b0;
        src_base_addr = '0;
        dest_base_addr = '0;
        rd_a_data = '0;
        rd_b_data = '0;
        for (i = 0; i < 2**AW; i++) begin
            src_mem[i] = (4 * (G + 1))'({$random(seed), $random(seed), $random(seed)});
        end
        for (r = 0; r < ROWS; r++) begin
            src_mem[tbl_src[r]] = {{(G+1){1'b1}}, (G+1)'((1 << G) + 1),
                                   (G+1)'(1 << G), (G+1)'(0)};
        end
        repeat (10) @(posedge clk);
        #1;
        reset_n = 1'b1;
        for (i = 0; i < 3; i++) begin
            @(negedge clk);
            check_ports(0, 0, 0, 1'b0);
        end
        for (r = 0; r < ROWS; r++) begin
            run_test(r);
        end
        $display("%0d tests run, %0d errors", ROWS, errors);
        if (errors == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== files.f ====
rtl/sigdecode_z_pkg.sv
rtl/sigdecode_z_unit.sv
rtl/sigdecode_z_ctrl.sv
rtl/sigdecode_z_addr_counter.sv
rtl/sigdecode_z_top.sv
sim/sigdecode_z_props.sv
sim/sigdecode_z_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= sigdecode_z_tb
DUT_TOP   ?= sigdecode_z_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= No errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(DUT_TOP) \
		rtl/sigdecode_z_pkg.sv rtl/sigdecode_z_unit.sv rtl/sigdecode_z_ctrl.sv \
		rtl/sigdecode_z_addr_counter.sv rtl/sigdecode_z_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
